// ==== logic/board_io_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Board I/O shared definitions
// Widths, MMIO register map, ID word and reset sequencer states
////////////////////////////////////////////////////////////////////////////

package board_io_pkg;

	// Widths
	localparam int GPIO_WIDTH      = 32;	// Pins per port
	localparam int MMIO_ADDR_WIDTH = 4;	// Register address bits
	localparam int SANITY_WIDTH    = 16;	// Reset stretch counter

	typedef logic [GPIO_WIDTH-1:0]      gpio_word_t;	// Pin values, dirs, reg data
	typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;	// Bus register address
	typedef logic [SANITY_WIDTH-1:0]    sanity_count_t;	// Sanity counter

	// Register map as seen on the bus
	localparam mmio_addr_t ADDR_OUT = 4'h0;	// Output latch
	localparam mmio_addr_t ADDR_DIR = 4'h1;	// Drive enables, 1 = output
	localparam mmio_addr_t ADDR_IN  = 4'h2;	// Pin state, read only
	localparam mmio_addr_t ADDR_SET = 4'h3;	// OR into output latch
	localparam mmio_addr_t ADDR_CLR = 4'h4;	// Clear bits in output latch
	localparam mmio_addr_t ADDR_ID  = 4'h5;	// Identification, read only

	// Decoded register select
	typedef enum logic [2:0]
	{
		REG_OUT  = 3'd0,
		REG_DIR  = 3'd1,
		REG_IN   = 3'd2,
		REG_SET  = 3'd3,
		REG_CLR  = 3'd4,
		REG_ID   = 3'd5,
		REG_NONE = 3'd7	// Any unmapped address
	} mmio_reg_e;

	// Value returned by REG_ID
	localparam gpio_word_t BOARD_IO_ID = 32'hB010_0A01;

	// Count where the core reset is released
	localparam sanity_count_t SANITY_TARGET = 16'hAA55;

	// Reset sequencer
	typedef enum logic [1:0]
	{
		RS_HOLD  = 2'd0,	// External reset asserted
		RS_COUNT = 2'd1,	// Stretching after release
		RS_RUN   = 2'd2	// Core out of reset
	} reset_state_e;

endpackage

// ==== logic/mmio_bus_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Decoded MMIO access
// Carries register select, strobes and write data from the decode stage
// to the register and readback stages
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface mmio_bus_if;

	board_io_pkg::mmio_reg_e  sel;		// Decoded register
	logic                     wr;		// Write strobe, writable regs only
	logic                     rd;		// Read strobe
	board_io_pkg::gpio_word_t wdata;	// Write data

	// Decode stage drives everything
	modport decoder
	(
		output sel, wr, rd, wdata
	);

	// Register stage
	modport regs
	(
		input sel, wr, rd, wdata
	);

	// Readback only needs the select and read strobe
	modport readback
	(
		input sel, rd
	);

endinterface

// ==== logic/reset_sanity.sv ====
////////////////////////////////////////////////////////////////////////////
// Reset sanity sequencer
// Holds the core in reset until a counter reaches the sanity target
// after the external reset is released
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reset_sanity
(
	input  logic clock_50mhz,
	input  logic reset2a,		// External reset, active high
	output logic core_reset_o,	// Stretched internal reset
	output logic reset_busy_o	// Same reset for the board pins
);

	board_io_pkg::reset_state_e  state;
	board_io_pkg::sanity_count_t count;

	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			state        <= board_io_pkg::RS_HOLD;
			count        <= '0;	// Restart the stretch
			core_reset_o <= 1'b1;
		end
		else
		begin
			case (state)
				board_io_pkg::RS_HOLD:
				begin
					state        <= board_io_pkg::RS_COUNT;	// Released, start counting
					core_reset_o <= 1'b1;
				end
				board_io_pkg::RS_COUNT:
				begin
					if (count == board_io_pkg::SANITY_TARGET)
					begin
						state        <= board_io_pkg::RS_RUN;
						core_reset_o <= 1'b0;	// Drops on the edge after target
					end
					else
						count <= count + 1'b1;
				end
				board_io_pkg::RS_RUN:
					core_reset_o <= 1'b0;
				default:
				begin
					// Unreachable encoding, start over
					state        <= board_io_pkg::RS_HOLD;
					core_reset_o <= 1'b1;
				end
			endcase
		end
	end

	assign reset_busy_o = core_reset_o;	// Pin copy

endmodule

// ==== logic/mmio_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// MMIO decode
// Registers the bus strobes and maps the address to a register select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mmio_decode
(
	input  logic                     clock_50mhz,
	input  logic                     core_reset_i,
	input  board_io_pkg::mmio_addr_t mmio_addr_i,
	input  board_io_pkg::gpio_word_t mmio_wdata_i,
	input  logic                     mmio_wr_i,
	input  logic                     mmio_rd_i,
	mmio_bus_if.decoder              bus
);

	board_io_pkg::mmio_reg_e sel_next;
	logic                    writable;

	// Address to register select
	always_comb
	begin
		case (mmio_addr_i)
			board_io_pkg::ADDR_OUT: sel_next = board_io_pkg::REG_OUT;
			board_io_pkg::ADDR_DIR: sel_next = board_io_pkg::REG_DIR;
			board_io_pkg::ADDR_IN:  sel_next = board_io_pkg::REG_IN;
			board_io_pkg::ADDR_SET: sel_next = board_io_pkg::REG_SET;
			board_io_pkg::ADDR_CLR: sel_next = board_io_pkg::REG_CLR;
			board_io_pkg::ADDR_ID:  sel_next = board_io_pkg::REG_ID;
			default:                sel_next = board_io_pkg::REG_NONE;
		endcase
	end

	// Only these four take a write
	// IN, ID and unmapped addresses swallow it here
	always_comb
	begin
		case (sel_next)
			board_io_pkg::REG_OUT,
			board_io_pkg::REG_DIR,
			board_io_pkg::REG_SET,
			board_io_pkg::REG_CLR: writable = 1'b1;
			default:               writable = 1'b0;
		endcase
	end

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			bus.sel <= board_io_pkg::REG_NONE;
			bus.wr  <= 1'b0;	// Strobes dropped during reset
			bus.rd  <= 1'b0;
		end
		else
		begin
			bus.sel <= sel_next;
			bus.wr  <= mmio_wr_i & writable;
			bus.rd  <= mmio_rd_i;
		end
	end

	always_ff @(posedge clock_50mhz)
	begin
		bus.wdata <= mmio_wdata_i;	// Payload, qualified by wr
	end

endmodule

// ==== logic/gpio_port_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// GPIO port registers
// Output and direction latches with set and clear updates, and a
// two-flop synchronizer on the input pins
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_port_regs
(
	input  logic                     clock_50mhz,
	input  logic                     core_reset_i,
	mmio_bus_if.regs                 bus,
	input  board_io_pkg::gpio_word_t gpio_i,	// Pad input side
	output board_io_pkg::gpio_word_t gpio_o,	// Pad output side
	output board_io_pkg::gpio_word_t gpio_d_o,	// Pad drive enable
	output board_io_pkg::gpio_word_t pins_sync_o	// Synchronized pad state
);

	board_io_pkg::gpio_word_t out_q;
	board_io_pkg::gpio_word_t dir_q;
	board_io_pkg::gpio_word_t out_next;
	board_io_pkg::gpio_word_t dir_next;
	board_io_pkg::gpio_word_t sync_1;
	board_io_pkg::gpio_word_t sync_2;

	// Next latch values for the decoded write
	always_comb
	begin
		out_next = out_q;
		dir_next = dir_q;

		if (bus.wr)
		begin
			case (bus.sel)
				board_io_pkg::REG_OUT:
					out_next = bus.wdata;		// Replace
				board_io_pkg::REG_DIR:
					dir_next = bus.wdata;		// Replace
				board_io_pkg::REG_SET:
					out_next = out_q | bus.wdata;	// Ones set bits
				board_io_pkg::REG_CLR:
					out_next = out_q & ~bus.wdata;	// Ones clear bits
				default:
				begin
					// Decode never raises wr for other selects
					out_next = out_q;
					dir_next = dir_q;
				end
			endcase
		end
	end

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			out_q <= '0;
			dir_q <= '0;	// All pins inputs
		end
		else
		begin
			out_q <= out_next;
			dir_q <= dir_next;
		end
	end

	// Pad input crosses in from outside the clock domain
	always_ff @(posedge clock_50mhz)
	begin
		sync_1 <= gpio_i;
		sync_2 <= sync_1;
	end

	assign gpio_o      = out_q;
	assign gpio_d_o    = dir_q;
	assign pins_sync_o = sync_2;

endmodule

// ==== logic/mmio_readback.sv ====
////////////////////////////////////////////////////////////////////////////
// MMIO readback
// Selects the read word for a decoded read and returns it with a
// one-cycle rvalid pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mmio_readback
(
	input  logic                     clock_50mhz,
	input  logic                     core_reset_i,
	mmio_bus_if.readback             bus,
	input  board_io_pkg::gpio_word_t out_i,	// Output latch
	input  board_io_pkg::gpio_word_t dir_i,	// Drive enables
	input  board_io_pkg::gpio_word_t pins_i,	// Synchronized pads
	output board_io_pkg::gpio_word_t mmio_rdata_o,
	output logic                     mmio_rvalid_o
);

	board_io_pkg::gpio_word_t rd_word;
	board_io_pkg::gpio_word_t pad_view;

	// Driven pins loop back the latch, as the pad would show it
	assign pad_view = (pins_i & ~dir_i) | (out_i & dir_i);

	always_comb
	begin
		case (bus.sel)
			board_io_pkg::REG_OUT: rd_word = out_i;
			board_io_pkg::REG_DIR: rd_word = dir_i;
			board_io_pkg::REG_IN:  rd_word = pad_view;
			board_io_pkg::REG_SET,
			board_io_pkg::REG_CLR: rd_word = out_i;	// Latch after set/clear
			board_io_pkg::REG_ID:  rd_word = board_io_pkg::BOARD_IO_ID;
			default:               rd_word = '0;	// Unmapped
		endcase
	end

	// Latch values here are still pre-write when wr and rd share a cycle
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			mmio_rvalid_o <= 1'b0;
			mmio_rdata_o  <= '0;
		end
		else
		begin
			mmio_rvalid_o <= bus.rd;	// One pulse per decoded read
			if (bus.rd)
				mmio_rdata_o <= rd_word;
		end
	end

endmodule

// ==== logic/board_io_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Board I/O top level
// Reset sequencer and a memory-mapped 32-pin GPIO port on a strobe bus,
// with pads split into input, output and drive-enable wires
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_top
(
	input  logic                     clock_50mhz,
	input  logic                     reset2a,
	input  board_io_pkg::mmio_addr_t mmio_addr_i,
	input  board_io_pkg::gpio_word_t mmio_wdata_i,
	input  logic                     mmio_wr_i,
	input  logic                     mmio_rd_i,
	input  board_io_pkg::gpio_word_t gpio_i,
	output board_io_pkg::gpio_word_t mmio_rdata_o,
	output logic                     mmio_rvalid_o,
	output board_io_pkg::gpio_word_t gpio_o,
	output board_io_pkg::gpio_word_t gpio_d_o,	// 1 = pin driven
	output logic                     reset_busy_o
);

	logic                     core_reset;	// Stretched reset for all stages
	board_io_pkg::gpio_word_t pins_sync;	// Synchronized pads to readback

	mmio_bus_if mmio_bus ();	// Decode to execute and result

	reset_sanity i_reset_sanity
	(
		.clock_50mhz  (clock_50mhz),
		.reset2a      (reset2a),
		.core_reset_o (core_reset),
		.reset_busy_o (reset_busy_o)
	);

	mmio_decode i_mmio_decode
	(
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.mmio_addr_i  (mmio_addr_i),
		.mmio_wdata_i (mmio_wdata_i),
		.mmio_wr_i    (mmio_wr_i),
		.mmio_rd_i    (mmio_rd_i),
		.bus          (mmio_bus.decoder)
	);

	gpio_port_regs i_gpio_port_regs
	(
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.bus          (mmio_bus.regs),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.gpio_d_o     (gpio_d_o),
		.pins_sync_o  (pins_sync)
	);

	// Readback sees the same latches that drive the pads
	mmio_readback i_mmio_readback
	(
		.clock_50mhz   (clock_50mhz),
		.core_reset_i  (core_reset),
		.bus           (mmio_bus.readback),
		.out_i         (gpio_o),
		.dir_i         (gpio_d_o),
		.pins_i        (pins_sync),
		.mmio_rdata_o  (mmio_rdata_o),
		.mmio_rvalid_o (mmio_rvalid_o)
	);

endmodule

// ==== testbench/board_io_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// Board I/O protocol checker
// Concurrent assertions on the read pulse and on reset behaviour,
// bound into the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_chk
(
	input logic                     clock_50mhz,
	input logic                     busy_i,		// Core reset copy
	input logic                     rd_i,		// Bus read strobe
	input logic                     rvalid_i,	// Read data pulse
	input board_io_pkg::gpio_word_t dir_i		// Pad drive enables
);

	int violations = 0;	// Failed assertions so far

	// Two pulses in a row need two strobes in a row
	a_rvalid_single: assert property (@(posedge clock_50mhz)
		(rvalid_i && $past(rvalid_i)) |-> ($past(rd_i, 2) && $past(rd_i, 3)))
	else
	begin
		violations++;
		$error("rvalid high on two cycles without two reads");
	end

	// One cycle of slack on reset entry, the stages see reset an edge late
	a_busy_no_rvalid: assert property (@(posedge clock_50mhz)
		(busy_i && $past(busy_i)) |-> !rvalid_i)
	else
	begin
		violations++;
		$error("rvalid pulse while the core is held in reset");
	end

	a_busy_no_drive: assert property (@(posedge clock_50mhz)
		(busy_i && $past(busy_i)) |-> (dir_i == '0))
	else
	begin
		violations++;
		$error("pins driven while the core is held in reset");
	end

	// Strobe must clear both decode and readback outside reset
	a_read_returns: assert property (@(posedge clock_50mhz)
		($past(rd_i, 2) && !$past(busy_i, 2) && !$past(busy_i, 1)) |-> rvalid_i)
	else
	begin
		violations++;
		$error("read strobe without rvalid two cycles later");
	end

endmodule

bind board_io_top board_io_chk i_board_io_chk
(
	.clock_50mhz (clock_50mhz),
	.busy_i      (reset_busy_o),
	.rd_i        (mmio_rd_i),
	.rvalid_i    (mmio_rvalid_o),
	.dir_i       (gpio_d_o)
);

// ==== testbench/board_io_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Board I/O testbench
// Seeded random MMIO traffic against a GPIO reference model, plus the
// reset stretch and a reset in mid-run
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_tb;

	localparam int RESET_CYCLES    = 16;	// Power-on reset2a hold
	localparam int RESET_BOUND     = 44000;	// Max stretch after release
	localparam int NUM_RAND_OPS    = 600;
	localparam int NUM_PIN_TRIALS  = 32;	// Seven cycles each
	localparam int NUM_OPS         = NUM_RAND_OPS + 8 + 7 * NUM_PIN_TRIALS + 16;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * RESET_BOUND + 20 * NUM_OPS + 1000;

	logic                     clock_50mhz;
	logic                     reset2a;
	board_io_pkg::mmio_addr_t mmio_addr_i;
	board_io_pkg::gpio_word_t mmio_wdata_i;
	logic                     mmio_wr_i;
	logic                     mmio_rd_i;
	board_io_pkg::gpio_word_t gpio_i;
	board_io_pkg::gpio_word_t mmio_rdata_o;
	logic                     mmio_rvalid_o;
	board_io_pkg::gpio_word_t gpio_o;
	board_io_pkg::gpio_word_t gpio_d_o;
	logic                     reset_busy_o;

	int                       seed;
	int                       cyc;		// Edges seen by the stimulus loop
	logic                     busy_low;		// Busy must stay low from here on
	board_io_pkg::gpio_word_t out_m;		// Model output register
	board_io_pkg::gpio_word_t dir_m;		// Model direction register
	board_io_pkg::gpio_word_t exp_out [2];	// [1] is due on the pins now
	board_io_pkg::gpio_word_t exp_dir [2];
	int                       rd_due_q [$];	// Edge where each read returns
	board_io_pkg::gpio_word_t rd_data_q [$];

	board_io_top i_board_io_top
	(
		.clock_50mhz   (clock_50mhz),
		.reset2a       (reset2a),
		.mmio_addr_i   (mmio_addr_i),
		.mmio_wdata_i  (mmio_wdata_i),
		.mmio_wr_i     (mmio_wr_i),
		.mmio_rd_i     (mmio_rd_i),
		.gpio_i        (gpio_i),
		.mmio_rdata_o  (mmio_rdata_o),
		.mmio_rvalid_o (mmio_rvalid_o),
		.gpio_o        (gpio_o),
		.gpio_d_o      (gpio_d_o),
		.reset_busy_o  (reset_busy_o)
	);

	always #10 clock_50mhz = ~clock_50mhz;	// 50 MHz

	task automatic stop_on_failure();
		$display("TB FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_word(input string name, input board_io_pkg::gpio_word_t expected,
		input board_io_pkg::gpio_word_t actual);
		if (actual !== expected)
		begin
			$display("error %s expected 0x%08h got 0x%08h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// Read value from the register map rules
	function automatic board_io_pkg::gpio_word_t read_model(
		input board_io_pkg::mmio_addr_t addr);
		board_io_pkg::gpio_word_t v;
		int                       b;
		v = '0;
		case (addr)
			board_io_pkg::ADDR_OUT: v = out_m;
			board_io_pkg::ADDR_DIR: v = dir_m;
			board_io_pkg::ADDR_IN:
			begin
				for (b = 0; b < board_io_pkg::GPIO_WIDTH; b++)
					v[b] = dir_m[b] ? out_m[b] : gpio_i[b];	// Driven pin shows the latch
			end
			board_io_pkg::ADDR_SET: v = out_m;
			board_io_pkg::ADDR_CLR: v = out_m;
			board_io_pkg::ADDR_ID:  v = board_io_pkg::BOARD_IO_ID;
			default:                v = '0;
		endcase
		return v;
	endfunction

	task automatic apply_write(input board_io_pkg::mmio_addr_t addr,
		input board_io_pkg::gpio_word_t d);
		case (addr)
			board_io_pkg::ADDR_OUT: out_m = d;
			board_io_pkg::ADDR_DIR: dir_m = d;
			board_io_pkg::ADDR_SET: out_m = out_m | d;
			board_io_pkg::ADDR_CLR: out_m = out_m & ~d;
			default:                ;	// IN, ID, unmapped ignore writes
		endcase
	endtask

	// Runs right after an edge
	task automatic check_outputs();
		check_word("gpio_o", exp_out[1], gpio_o);
		check_word("gpio_d_o", exp_dir[1], gpio_d_o);
		if (rd_due_q.size() != 0 && rd_due_q[0] == cyc)
		begin
			check_flag("mmio_rvalid_o", 1'b1, mmio_rvalid_o);
			check_word("mmio_rdata_o", rd_data_q[0], mmio_rdata_o);
			void'(rd_due_q.pop_front());
			void'(rd_data_q.pop_front());
		end
		else
			check_flag("mmio_rvalid_o", 1'b0, mmio_rvalid_o);
		if (busy_low)
			check_flag("reset_busy_o", 1'b0, reset_busy_o);
		if (i_board_io_top.i_board_io_chk.violations != 0)
		begin
			$display("an assertion in board_io_chk failed");
			stop_on_failure();
		end
	endtask

	// Drive one cycle of bus strobes, update the model, check after the edge
	task automatic run_cycle(input logic wr, input logic rd, input board_io_pkg::mmio_addr_t addr,
		input board_io_pkg::gpio_word_t wdata);
		logic gated;
		gated        = reset2a || reset_busy_o;	// DUT drops these strobes
		mmio_wr_i    = wr;
		mmio_rd_i    = rd;
		mmio_addr_i  = addr;
		mmio_wdata_i = wdata;
		if (rd && !gated)
		begin
			rd_due_q.push_back(cyc + 2);	// Pre-write value on a shared cycle
			rd_data_q.push_back(read_model(addr));
		end
		if (wr && !gated)
			apply_write(addr, wdata);
		if (reset2a)
		begin
			out_m = '0;
			dir_m = '0;
		end
		exp_out[1] = exp_out[0];	// Pins follow two edges later
		exp_out[0] = out_m;
		exp_dir[1] = exp_dir[0];
		exp_dir[0] = dir_m;
		@(posedge clock_50mhz);
		#1;
		cyc++;
		check_outputs();
	endtask

	task automatic random_access();
		logic [31:0]              r;
		logic [31:0]              w;
		board_io_pkg::mmio_addr_t addr;
		r    = $random(seed);
		w    = $random(seed);
		addr = r[12] ? {1'b0, r[2:0]} : r[3:0];	// Lean toward mapped registers
		run_cycle(r[8], r[9], addr, w);
	endtask

	// Release reset2a and wait out the sanity stretch
	task automatic release_reset(input logic strobe);
		int waited;
		waited  = 0;
		reset2a = 1'b0;
		while (reset_busy_o === 1'b1)
		begin
			if (waited >= RESET_BOUND)
			begin
				$display("reset_busy_o still high %0d cycles after reset release", waited);
				stop_on_failure();
			end
			check_word("mmio_rdata_o", '0, mmio_rdata_o);	// Held clear in reset
			if (strobe)
				run_cycle(1'b1, 1'b1,
					waited[0] ? board_io_pkg::ADDR_DIR : board_io_pkg::ADDR_OUT,
					$random(seed));	// Every busy cycle up to the last, all dropped
			else
				run_cycle(1'b0, 1'b0, '0, '0);
			waited++;
		end
		busy_low = 1'b1;
	endtask

	initial
	begin
		int i;
		seed         = 7436;
		cyc          = 0;
		busy_low     = 1'b0;
		clock_50mhz  = 1'b0;
		reset2a      = 1'b1;
		mmio_addr_i  = '0;
		mmio_wdata_i = '0;
		mmio_wr_i    = 1'b0;
		mmio_rd_i    = 1'b0;
		gpio_i       = '0;
		out_m        = '0;
		dir_m        = '0;
		exp_out      = '{default: '0};
		exp_dir      = '{default: '0};
		repeat (RESET_CYCLES) @(posedge clock_50mhz);
		#1;
		check_flag("reset_busy_o", 1'b1, reset_busy_o);
		check_outputs();

		release_reset(1'b0);	// Power-on stretch

		repeat (NUM_RAND_OPS) random_access();	// Writes, reads, back-to-back
		for (i = 0; i < 8; i++)
			run_cycle(1'b0, 1'b1, i[3:0], '0);	// Burst over the map, ID and unmapped

		// Mixed input reads
		for (i = 0; i < NUM_PIN_TRIALS; i++)
		begin
			run_cycle(1'b1, 1'b0, board_io_pkg::ADDR_OUT, $random(seed));
			run_cycle(1'b1, 1'b0, board_io_pkg::ADDR_DIR, $random(seed));
			gpio_i = $random(seed);
			repeat (4) run_cycle(1'b0, 1'b0, '0, '0);	// Synchronizer settles
			run_cycle(1'b0, 1'b1, board_io_pkg::ADDR_IN, '0);
		end

		// Reset in mid-run, with a read one cycle before the assertion
		run_cycle(1'b1, 1'b0, board_io_pkg::ADDR_OUT, $random(seed));
		run_cycle(1'b1, 1'b1, board_io_pkg::ADDR_DIR, $random(seed));
		busy_low = 1'b0;
		reset2a  = 1'b1;
		random_access();
		check_flag("reset_busy_o", 1'b1, reset_busy_o);	// One edge after reset2a
		repeat (7) random_access();
		release_reset(1'b1);
		run_cycle(1'b0, 1'b1, board_io_pkg::ADDR_OUT, '0);
		run_cycle(1'b0, 1'b1, board_io_pkg::ADDR_DIR, '0);
		repeat (3) run_cycle(1'b0, 1'b0, '0, '0);	// Drain reads in flight

		$display("TB PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_50mhz);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		stop_on_failure();
	end

endmodule

// ==== board_io_top.f ====
logic/board_io_pkg.sv
logic/mmio_bus_if.sv
logic/reset_sanity.sv
logic/mmio_decode.sv
logic/gpio_port_regs.sv
logic/mmio_readback.sv
logic/board_io_top.sv
testbench/board_io_chk.sv
testbench/board_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the board I/O testbench with Verilator and run it.
# $fatal in the testbench gives a non-zero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module board_io_tb \
	--Mdir obj_dir \
	-f board_io_top.f

./obj_dir/Vboard_io_tb +verilator+error+limit+100
